// ==== rtl/break_select_pkg.sv ====
package break_select_pkg;

    // default problem size, the top level may override both through its parameters
    localparam int NUM_CLAUSES_DEF = 20; // clauses held by the clause table
    localparam int NUM_ROWS_DEF    = 3;  // literals per clause, so one candidate row per literal

    // a break value can reach the full clause count, hence the +1
    localparam int NUM_CLAUSES_BITS_DEF = $clog2(NUM_CLAUSES_DEF + 1);

    // the random source is shared with the rest of the solver and its width never changes
    localparam int RAND_BITS = 8;

    // noise probability of 0x40 / 0x100, one random pick in four when no freebie exists
    localparam logic [RAND_BITS - 1 : 0] NOISE_THRESH_DEF = 8'h40;

    // why a candidate was chosen
    // freebie has code zero so that a cleared result register reads as freebie
    typedef enum logic [1:0] {
        REASON_FREEBIE = 2'd0, // some row breaks no clause
        REASON_NOISE   = 2'd1, // random walk step
        REASON_GREEDY  = 2'd2  // lowest break value among the rows
    } select_reason_t;

endpackage

// ==== rtl/break_value_counter.sv ====
`timescale 1ns/1ps

// counts how many live clauses one candidate flip would break
// purely combinational, the selector samples the result one cycle after the rows settle
module break_value_counter #(
    parameter int NUM_CLAUSES      = break_select_pkg::NUM_CLAUSES_DEF,
    parameter int NUM_CLAUSES_BITS = break_select_pkg::NUM_CLAUSES_BITS_DEF
) (
    input  logic [NUM_CLAUSES - 1 : 0]      clause_broken_i, // 1 where the flip would break clause k
    input  logic [NUM_CLAUSES - 1 : 0]      mask_bits_i,     // clause table valid mask
    output logic [NUM_CLAUSES_BITS - 1 : 0] break_value_o,   // number of live clauses broken
    output logic [NUM_CLAUSES - 1 : 0]      clause_broken_o  // masked vector, passed downstream
);

    logic [NUM_CLAUSES - 1 : 0]      masked_bits;
    logic [NUM_CLAUSES_BITS - 1 : 0] sum_steps [NUM_CLAUSES]; // running total after bit i

    // empty slots of the clause table must never count as broken
    assign masked_bits = clause_broken_i & mask_bits_i;

    // ripple chain of incrementers, one stage per clause
    assign sum_steps[0] = NUM_CLAUSES_BITS'(masked_bits[0]);

    genvar i;
    generate
        for (i = 1; i < NUM_CLAUSES; i = i + 1) begin : g_sum
            assign sum_steps[i] = sum_steps[i - 1] + NUM_CLAUSES_BITS'(masked_bits[i]);
        end
    endgenerate

    assign break_value_o   = sum_steps[NUM_CLAUSES - 1]; // last stage holds the full count
    assign clause_broken_o = masked_bits; // the chosen row's vector goes on to the flip logic

endmodule

// ==== rtl/break_row_buffer.sv ====
`timescale 1ns/1ps

// collects the break vectors of one unsatisfied clause, one literal per strobe
// rows past NUM_ROWS are dropped until the batch closes with row_last_i
module break_row_buffer #(
    parameter int NUM_CLAUSES = break_select_pkg::NUM_CLAUSES_DEF,
    parameter int NUM_ROWS    = break_select_pkg::NUM_ROWS_DEF
) (
    input  logic                                           clk,
    input  logic                                           rst_i,
    input  logic                                           row_valid_i,   // one row per strobe
    input  logic                                           row_last_i,    // closes the batch
    input  logic [NUM_CLAUSES - 1 : 0]                     row_bits_i,
    output logic [NUM_ROWS - 1 : 0][NUM_CLAUSES - 1 : 0]   rows_o,
    output logic [$clog2(NUM_ROWS + 1) - 1 : 0]            valid_count_o, // rows stored last batch
    output logic                                           batch_full_o   // one cycle after last row
);

    localparam int COUNT_BITS = $clog2(NUM_ROWS + 1); // must hold NUM_ROWS itself

    logic [COUNT_BITS - 1 : 0]                   wr_ptr;     // next free slot, stops at NUM_ROWS
    logic [NUM_ROWS - 1 : 0][NUM_CLAUSES - 1 : 0] rows_q;
    logic                                         has_room;   // the current strobe lands in a slot
    logic [COUNT_BITS - 1 : 0]                    stored_cnt; // rows held once this strobe is taken

    assign has_room   = (wr_ptr < COUNT_BITS'(NUM_ROWS));
    assign stored_cnt = has_room ? wr_ptr + COUNT_BITS'(1) : wr_ptr;

    // each accepted strobe writes the slot under the write pointer
    always_ff @(posedge clk) begin
        if (row_valid_i && has_room) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (wr_ptr == COUNT_BITS'(r)) begin
                    rows_q[r] <= row_bits_i; // only the addressed slot moves
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr        <= '0;
            valid_count_o <= '0;
            batch_full_o  <= 1'b0;
        end else begin
            batch_full_o <= 1'b0; // a pulse, never held
            if (row_valid_i) begin
                if (row_last_i) begin
                    // freeze the batch size for the selector and rewind for the next clause
                    valid_count_o <= stored_cnt;
                    batch_full_o  <= 1'b1;
                    wr_ptr        <= '0;
                end else if (has_room) begin
                    wr_ptr <= wr_ptr + COUNT_BITS'(1);
                end
                // overflow rows without row_last_i leave the pointer parked at NUM_ROWS
            end
        end
    end

    // the selector reads the rows in the batch_full cycle
    // the next batch is not allowed to write before then, so no copy is needed
    assign rows_o = rows_q;

endmodule

// ==== rtl/heuristic_selector.sv ====
`timescale 1ns/1ps

// WalkSAT candidate choice over the break values of one batch
// freebie first, then a noise step with probability NOISE_THRESH / 256, then greedy
module heuristic_selector #(
    parameter int NUM_CLAUSES      = break_select_pkg::NUM_CLAUSES_DEF,
    parameter int NUM_ROWS         = break_select_pkg::NUM_ROWS_DEF,
    parameter int NUM_CLAUSES_BITS = break_select_pkg::NUM_CLAUSES_BITS_DEF,
    parameter logic [break_select_pkg::RAND_BITS - 1 : 0] NOISE_THRESH =
        break_select_pkg::NOISE_THRESH_DEF
) (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  logic                                              start_i,        // batch is complete
    input  logic [$clog2(NUM_ROWS + 1) - 1 : 0]               valid_count_i,  // rows to consider
    input  logic [NUM_ROWS - 1 : 0][NUM_CLAUSES_BITS - 1 : 0] break_values_i,
    input  logic [NUM_ROWS - 1 : 0][NUM_CLAUSES - 1 : 0]      broken_vecs_i,
    input  logic [break_select_pkg::RAND_BITS - 1 : 0]        rand_i,
    output logic                                              done_o,         // result valid pulse
    output logic [((NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1) - 1 : 0] sel_row_o,
    output logic [NUM_CLAUSES_BITS - 1 : 0]                   break_value_o,
    output break_select_pkg::select_reason_t                  reason_o,
    output logic [NUM_CLAUSES - 1 : 0]                        clause_broken_o
);

    localparam int COUNT_BITS = $clog2(NUM_ROWS + 1);
    localparam int IDX_BITS   = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1; // at least one bit

    logic                                 free_found; // some valid row breaks nothing
    logic [IDX_BITS - 1 : 0]              free_idx;   // lowest such row
    logic [IDX_BITS - 1 : 0]              min_idx;    // lowest row holding the minimum
    logic [NUM_CLAUSES_BITS - 1 : 0]      min_val;
    logic [IDX_BITS - 1 : 0]              noise_idx;  // rand_i folded onto the valid rows
    logic                                 take_noise;
    logic [IDX_BITS - 1 : 0]              pick_idx;
    break_select_pkg::select_reason_t     pick_reason;

    // scan the valid rows once, ascending, so ties resolve to the lower index
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        min_idx    = '0;
        min_val    = break_values_i[0]; // a batch always holds at least row 0
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (COUNT_BITS'(r) < valid_count_i) begin
                if (!free_found && (break_values_i[r] == '0)) begin
                    free_found = 1'b1;
                    free_idx   = IDX_BITS'(r);
                end
                if (break_values_i[r] < min_val) begin // strict compare keeps the first minimum
                    min_val = break_values_i[r];
                    min_idx = IDX_BITS'(r);
                end
            end
        end
    end

    // modulo by the batch size keeps the random walk inside the stored rows
    // valid_count_i is zero only after reset, before the first batch has closed
    assign noise_idx  = (valid_count_i == '0) ? '0 : IDX_BITS'(rand_i % valid_count_i);
    assign take_noise = (rand_i < NOISE_THRESH);

    always_comb begin
        if (free_found) begin
            pick_idx    = free_idx; // a free flip always wins, noise is not consulted
            pick_reason = break_select_pkg::REASON_FREEBIE;
        end else if (take_noise) begin
            pick_idx    = noise_idx;
            pick_reason = break_select_pkg::REASON_NOISE;
        end else begin
            pick_idx    = min_idx;
            pick_reason = break_select_pkg::REASON_GREEDY;
        end
    end

    // results are sampled at the end of the start cycle and then held until the next batch
    always_ff @(posedge clk) begin
        if (rst_i) begin
            done_o          <= 1'b0;
            sel_row_o       <= '0;
            break_value_o   <= '0;
            reason_o        <= break_select_pkg::REASON_FREEBIE;
            clause_broken_o <= '0;
        end else begin
            done_o <= start_i; // exactly one cycle after the batch_full pulse
            if (start_i) begin
                sel_row_o       <= pick_idx;
                break_value_o   <= break_values_i[pick_idx];
                reason_o        <= pick_reason;
                clause_broken_o <= broken_vecs_i[pick_idx]; // already masked by the counter
            end
        end
    end

endmodule

// ==== rtl/break_counter_selector.sv ====
`timescale 1ns/1ps

// candidate scoring stage: row buffer, one break counter per row, WalkSAT selector
// last row sampled at edge n, batch_full during cycle n+1, done_o during cycle n+2
module break_counter_selector #(
    parameter int NUM_CLAUSES      = break_select_pkg::NUM_CLAUSES_DEF,
    parameter int NUM_ROWS         = break_select_pkg::NUM_ROWS_DEF,
    parameter int NUM_CLAUSES_BITS = break_select_pkg::NUM_CLAUSES_BITS_DEF,
    parameter logic [break_select_pkg::RAND_BITS - 1 : 0] NOISE_THRESH =
        break_select_pkg::NOISE_THRESH_DEF
) (
    input  logic                                       clk,
    input  logic                                       rst_i,
    input  logic                                       row_valid_i,
    input  logic                                       row_last_i,
    input  logic [NUM_CLAUSES - 1 : 0]                 row_bits_i,
    input  logic [NUM_CLAUSES - 1 : 0]                 mask_i,    // held stable for the batch
    input  logic [break_select_pkg::RAND_BITS - 1 : 0] rand_i,    // stable in the batch_full cycle
    output logic                                       done_o,
    output logic [((NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1) - 1 : 0] sel_row_o,
    output logic [NUM_CLAUSES_BITS - 1 : 0]            break_value_o,
    output break_select_pkg::select_reason_t           reason_o,
    output logic [NUM_CLAUSES - 1 : 0]                 clause_broken_o
);

    localparam int COUNT_BITS = $clog2(NUM_ROWS + 1);

    logic [NUM_ROWS - 1 : 0][NUM_CLAUSES - 1 : 0]      rows;         // raw break vectors
    logic [COUNT_BITS - 1 : 0]                         valid_count;
    logic                                              batch_full;
    logic [NUM_ROWS - 1 : 0][NUM_CLAUSES_BITS - 1 : 0] break_values; // one count per row
    logic [NUM_ROWS - 1 : 0][NUM_CLAUSES - 1 : 0]      broken_vecs;  // rows after masking

    break_row_buffer #(
        .NUM_CLAUSES (NUM_CLAUSES),
        .NUM_ROWS    (NUM_ROWS)
    ) i_break_row_buffer (
        .clk           (clk),
        .rst_i         (rst_i),
        .row_valid_i   (row_valid_i),
        .row_last_i    (row_last_i),
        .row_bits_i    (row_bits_i),
        .rows_o        (rows),
        .valid_count_o (valid_count),
        .batch_full_o  (batch_full)
    );

    // every candidate is scored in parallel against the same clause table mask
    genvar r;
    generate
        for (r = 0; r < NUM_ROWS; r = r + 1) begin : g_counter
            break_value_counter #(
                .NUM_CLAUSES      (NUM_CLAUSES),
                .NUM_CLAUSES_BITS (NUM_CLAUSES_BITS)
            ) i_break_value_counter (
                .clause_broken_i (rows[r]),
                .mask_bits_i     (mask_i),
                .break_value_o   (break_values[r]),
                .clause_broken_o (broken_vecs[r])
            );
        end
    endgenerate

    heuristic_selector #(
        .NUM_CLAUSES      (NUM_CLAUSES),
        .NUM_ROWS         (NUM_ROWS),
        .NUM_CLAUSES_BITS (NUM_CLAUSES_BITS),
        .NOISE_THRESH     (NOISE_THRESH)
    ) i_heuristic_selector (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (batch_full),   // decide in the cycle after the last row
        .valid_count_i   (valid_count),
        .break_values_i  (break_values),
        .broken_vecs_i   (broken_vecs),
        .rand_i          (rand_i),
        .done_o          (done_o),
        .sel_row_o       (sel_row_o),
        .break_value_o   (break_value_o),
        .reason_o        (reason_o),
        .clause_broken_o (clause_broken_o)
    );

endmodule

// ==== tb/bcs_checks.svh ====
`ifndef BCS_CHECKS_SVH
`define BCS_CHECKS_SVH

// one compare task per result field of the DUT
// each mismatch prints one line and adds to case_errors of the enclosing module

task automatic check_row(
    input logic [ROW_BITS - 1 : 0] got,
    input logic [ROW_BITS - 1 : 0] exp
);
    if (got !== exp) begin
        $display("FAIL sel_row_o expected 0x%0h got 0x%0h", exp, got);
        case_errors++;
    end
endtask

task automatic check_break_value(
    input logic [BV_BITS - 1 : 0] got,
    input logic [BV_BITS - 1 : 0] exp
);
    if (got !== exp) begin
        $display("FAIL break_value_o expected 0x%0h got 0x%0h", exp, got);
        case_errors++;
    end
endtask

// the enum names follow the hex codes
task automatic check_reason(
    input break_select_pkg::select_reason_t got,
    input break_select_pkg::select_reason_t exp
);
    if (got !== exp) begin
        $display("FAIL reason_o expected 0x%0h got 0x%0h (%s, %s)",
                 exp, got, exp.name(), got.name());
        case_errors++;
    end
endtask

task automatic check_vector(
    input logic [NUM_CLAUSES - 1 : 0] got,
    input logic [NUM_CLAUSES - 1 : 0] exp
);
    if (got !== exp) begin
        $display("FAIL clause_broken_o expected 0x%0h got 0x%0h", exp, got);
        case_errors++;
    end
endtask

`endif

// ==== tb/tb_break_counter_selector.sv ====
`timescale 1ns/1ps

module tb_break_counter_selector;

    localparam int NUM_CLAUSES = break_select_pkg::NUM_CLAUSES_DEF;
    localparam int NUM_ROWS    = break_select_pkg::NUM_ROWS_DEF;
    localparam int BV_BITS     = break_select_pkg::NUM_CLAUSES_BITS_DEF;
    localparam int RAND_BITS   = break_select_pkg::RAND_BITS;
    localparam int ROW_BITS    = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
    localparam int MAX_STROBES = NUM_ROWS + 1; // one spare column carries the overflow strobe
    localparam int MAX_TESTS   = 64;
    localparam string GOLDEN_PATH = "tb/bcs_golden.txt";

    logic                             clk         = 1'b0;
    logic                             rst_i       = 1'b1; // held from time zero
    logic                             row_valid_i = 1'b0;
    logic                             row_last_i  = 1'b0;
    logic [NUM_CLAUSES - 1 : 0]       row_bits_i  = '0;
    logic [NUM_CLAUSES - 1 : 0]       mask_i      = '0;
    logic [RAND_BITS - 1 : 0]         rand_i      = '0;
    logic                             done_o;
    logic [ROW_BITS - 1 : 0]          sel_row_o;
    logic [BV_BITS - 1 : 0]           break_value_o;
    break_select_pkg::select_reason_t reason_o;
    logic [NUM_CLAUSES - 1 : 0]       clause_broken_o;

    // one entry per data line of the golden file
    logic [NUM_CLAUSES - 1 : 0]       g_mask   [MAX_TESTS];
    logic [RAND_BITS - 1 : 0]         g_rand   [MAX_TESTS];
    int                               g_strobes[MAX_TESTS]; // may exceed NUM_ROWS for overflow
    logic [NUM_CLAUSES - 1 : 0]       g_rows   [MAX_TESTS][MAX_STROBES];
    logic [ROW_BITS - 1 : 0]          g_row    [MAX_TESTS];
    logic [BV_BITS - 1 : 0]           g_bv     [MAX_TESTS];
    break_select_pkg::select_reason_t g_reason [MAX_TESTS];
    logic [NUM_CLAUSES - 1 : 0]       g_vec    [MAX_TESTS];

    int n_tests     = 0;
    bit loaded      = 1'b0;
    int cycle_cnt   = 0; // rising edges seen so far
    int case_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int pend_idx[$];     // batches whose done_o is still owed, oldest first
    int pend_due[$];     // cycle_cnt value at which each of them must show done_o

    `include "bcs_checks.svh"

    break_counter_selector #(
        .NOISE_THRESH (8'h40)
    ) i_break_counter_selector (
        .clk             (clk),
        .rst_i           (rst_i),
        .row_valid_i     (row_valid_i),
        .row_last_i      (row_last_i),
        .row_bits_i      (row_bits_i),
        .mask_i          (mask_i),
        .rand_i          (rand_i),
        .done_o          (done_o),
        .sel_row_o       (sel_row_o),
        .break_value_o   (break_value_o),
        .reason_o        (reason_o),
        .clause_broken_o (clause_broken_o)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic load_golden();
        int          fd;
        int          code;
        string       line;
        logic [31:0] v_mask, v_rand, v_cnt, v_r0, v_r1, v_r2, v_r3;
        logic [31:0] v_row, v_bv, v_reason, v_vec;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            $display("could not open the golden file %s", GOLDEN_PATH);
            fail_count++; // the run goes on with no cases and ends as a failure
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v_mask, v_rand,
                                   v_cnt, v_r0, v_r1, v_r2, v_r3, v_row, v_bv, v_reason, v_vec);
                    if (code != 11 || n_tests >= MAX_TESTS || v_cnt == 0 || v_cnt > MAX_STROBES)
                    begin
                        $display("a golden file line could not be used: %s", line);
                        fail_count++;
                    end else begin
                        g_mask[n_tests]    = v_mask[NUM_CLAUSES - 1 : 0];
                        g_rand[n_tests]    = v_rand[RAND_BITS - 1 : 0];
                        g_strobes[n_tests] = int'(v_cnt);
                        g_rows[n_tests][0] = v_r0[NUM_CLAUSES - 1 : 0];
                        g_rows[n_tests][1] = v_r1[NUM_CLAUSES - 1 : 0];
                        g_rows[n_tests][2] = v_r2[NUM_CLAUSES - 1 : 0];
                        g_rows[n_tests][3] = v_r3[NUM_CLAUSES - 1 : 0];
                        g_row[n_tests]     = v_row[ROW_BITS - 1 : 0];
                        g_bv[n_tests]      = v_bv[BV_BITS - 1 : 0];
                        g_reason[n_tests]  = break_select_pkg::select_reason_t'(v_reason[1:0]);
                        g_vec[n_tests]     = v_vec[NUM_CLAUSES - 1 : 0];
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // streams one batch, ends 1 ns after the edge that samples its last row
    task automatic run_batch(input int t);
        int s;
        mask_i = g_mask[t]; // both stay put until the next batch starts
        rand_i = g_rand[t];
        for (s = 0; s < g_strobes[t]; s++) begin
            row_valid_i = 1'b1;
            row_last_i  = (s == g_strobes[t] - 1);
            row_bits_i  = g_rows[t][s];
            if (row_last_i) begin
                pend_idx.push_back(t);
                pend_due.push_back(cycle_cnt + 2); // sampled next edge, done_o one edge later
            end
            @(posedge clk);
            #1;
        end
        row_valid_i = 1'b0;
        row_last_i  = 1'b0;
    endtask

    task automatic report_case(input string label);
        if (case_errors == 0) begin
            pass_count++;
            $display("case %s: ok", label);
        end else begin
            fail_count++;
            $display("case %s: %0d errors", label, case_errors);
        end
    endtask

    task automatic check_result(input int t);
        check_row(sel_row_o, g_row[t]);
        check_break_value(break_value_o, g_bv[t]);
        check_reason(reason_o, g_reason[t]);
        check_vector(clause_broken_o, g_vec[t]);
        report_case($sformatf("%0d", t));
    endtask

    initial begin : driver
        int t;
        int gap;
        void'($urandom(24)); // seeds this process, the gaps below continue the stream
        load_golden();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(posedge clk);
        #1;
        for (t = 0; t < n_tests; t++) begin
            run_batch(t);
            // every fourth gap is the minimum of one idle cycle between batches
            gap = (t % 4 == 3) ? 1 : 1 + int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        while (pend_idx.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("summary: %0d of %0d cases ok, %0d failures",
                 pass_count, n_tests + 1, fail_count);
        if (fail_count == 0 && n_tests > 0 && pass_count == n_tests + 1) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // matches each done_o pulse with the oldest batch still owed a result
    initial begin : monitor
        int t;
        int due;
        bit prev_done;
        prev_done = 1'b0;
        @(negedge rst_i);
        case_errors = 0;
        if (done_o !== 1'b0) begin
            $display("done_o is not low after reset");
            case_errors++;
        end
        check_row(sel_row_o, '0);
        check_break_value(break_value_o, '0);
        check_reason(reason_o, break_select_pkg::REASON_FREEBIE); // code zero
        check_vector(clause_broken_o, '0);
        report_case("reset");
        forever begin
            @(posedge clk);
            #1; // registered outputs have settled by now
            if (done_o && prev_done) begin
                $display("done_o stayed high for more than one cycle");
                fail_count++;
            end else if (done_o && pend_idx.size() == 0) begin
                $display("done_o rose while no batch was pending");
                fail_count++;
            end else if (done_o) begin
                t = pend_idx.pop_front();
                due = pend_due.pop_front();
                case_errors = 0;
                if (due != cycle_cnt) begin
                    $display("case %0d: done did not arrive on time, it came %0d cycles early",
                             t, due - cycle_cnt);
                    case_errors++;
                end
                check_result(t);
            end else if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
                t = pend_idx.pop_front();
                due = pend_due.pop_front();
                $display("case %0d: done did not arrive on time, still low at cycle %0d", t, due);
                fail_count++;
            end
            prev_done = done_o;
        end
    end

    initial begin : watchdog
        wait (loaded);
        #((n_tests * (NUM_ROWS + 6) + 100) * 4); // worst case per batch plus reset and drain
        $display("timeout: the run did not finish in the time allowed for %0d cases", n_tests);
        $display("test failed");
        $finish;
    end

endmodule

// ==== tb/bcs_golden.txt ====
// mask rand strobes row0 row1 row2 row3 | exp_row exp_break exp_reason exp_vector, all hex
// reason 0 freebie, 1 noise, 2 greedy; unused row columns are 00000 and not driven
FFF00 80 1 12345 00000 00000 00000 0 04 2 12300
0F0F0 10 1 ABCDE 00000 00000 00000 0 06 1 0B0D0
000FF 05 1 FFF00 00000 00000 00000 0 00 0 00000
FFFFF 3F 1 80001 00000 00000 00000 0 02 1 80001
FFFFF 40 1 00007 00000 00000 00000 0 03 2 00007
0FFFF 00 3 00011 F0000 30000 00000 1 00 0 00000
0FFFF FF 3 00100 10000 00000 00000 1 00 0 00000
FFFFF 20 3 00003 00001 00000 00000 2 00 0 00000
FFFFF 80 3 00007 00003 00030 00000 1 02 2 00003
FFFFF FF 3 00001 00010 00100 00000 0 01 2 00001
00FFF 41 3 000FF FF00F F0003 00000 2 02 2 00003
FFFFF C0 3 FFFFF 00300 30000 00000 1 02 2 00300
FFFFF 90 1 FFFFF 00000 00000 00000 0 14 2 FFFFF
FFFFF 05 3 00001 00003 000FF 00000 2 08 1 000FF
FFFFF 3F 3 0000F 00001 00003 00000 0 04 1 0000F
0FF00 1C 3 00100 FFFFF 00300 00000 1 08 1 0FF00
FFFFF 07 2 00001 000F0 00000 00000 1 04 1 000F0
FFFFF 80 3 00003 00007 00000 00000 2 00 0 00000
FFFFF 80 2 0000F 00011 00000 00000 1 02 2 00011
FFFFF 00 2 00700 00001 00000 00000 0 03 1 00700
FFFFF 80 4 00007 0000F 00003 00000 2 02 2 00003
FFFFF 04 4 00001 00030 00F00 00000 1 02 1 00030
FFFFF 80 1 00100 00000 00000 00000 0 01 2 00100
FFFFF 80 3 00003 00000 00001 00000 1 00 0 00000
FFFFF 80 1 0001F 00000 00000 00000 0 05 2 0001F
00000 00 3 FFFFF FFFFF FFFFF 00000 0 00 0 00000

// ==== break_select.f ====
+incdir+tb
rtl/break_select_pkg.sv
rtl/break_value_counter.sv
rtl/break_row_buffer.sv
rtl/heuristic_selector.sv
rtl/break_counter_selector.sv
tb/tb_break_counter_selector.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and decides on the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f break_select.f \
    --top-module tb_break_counter_selector \
    -o sim_break_select

./obj_dir/sim_break_select | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
